// File: design/otp_scrmbl_top.sv
`timescale 1ns/10ps
`default_nettype none

module otp_scrmbl_top #(
  parameter int unsigned            NumRounds = 31,
  parameter scrmbl_pkg::key_table_t KeyTable  = scrmbl_pkg::default_keys,
  parameter scrmbl_pkg::iv_table_t  IvTable   = scrmbl_pkg::default_ivs
) (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  // command side
  input  scrmbl_pkg::cmd_e            cmd_i,
  input  wire [scrmbl_pkg::sel_w-1:0] sel_i,
  input  present_pkg::block_t         data_i,
  input  wire                         valid_i,
  output logic                        ready_o,
  // result side
  output present_pkg::block_t         data_o,
  output logic                        valid_o
);

  scrmbl_ctrl_if ctrl_if ();

  present_pkg::block_t data_state, enc_out, digest_state, enc_out_xor;

  scrmbl_decode #(
    .NumRounds(NumRounds)
  ) u_decode (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (cmd_i),
    .sel_i  (sel_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .ctrl_o (ctrl_if.decode_mp)
  );

  scrmbl_execute #(
    .NumRounds(NumRounds),
    .KeyTable (KeyTable)
  ) u_execute (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_i        (data_i),
    .ctrl_i        (ctrl_if.execute_mp),
    .digest_state_i(digest_state),
    .enc_out_xor_i (enc_out_xor),
    .data_state_o  (data_state),
    .enc_out_o     (enc_out)
  );

  scrmbl_result #(
    .IvTable(IvTable)
  ) u_result (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_if.result_mp),
    .data_state_i  (data_state),
    .enc_out_i     (enc_out),
    .digest_state_o(digest_state),
    .enc_out_xor_o (enc_out_xor),
    .data_o        (data_o),
    .valid_o       (valid_o)
  );

endmodule

`default_nettype wire

// File: design/present_pkg.sv
`default_nettype none

package present_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // widths and types
  //////////////////////////////////////////////////////////////////////////////

  // cipher block, key and round index widths
  localparam int block_w = 64;
  localparam int key_w   = 128;
  localparam int idx_w   = 5;

  typedef logic [block_w-1:0] block_t;
  typedef logic [key_w-1:0]   key_t;
  typedef logic [idx_w-1:0]   idx_t;

  // 4-bit s-box and its inverse, entry 0 in the low nibble
  localparam logic [15:0][3:0] sbox4     = 64'h21748fe3da09b65c;
  localparam logic [15:0][3:0] sbox4_inv = 64'ha970364bd21c8fe5;

  //////////////////////////////////////////////////////////////////////////////
  // round primitives
  //////////////////////////////////////////////////////////////////////////////

  // substitution layer over all 16 nibbles
  function automatic block_t sbox_layer_f(block_t data, bit inv);
    block_t res;
    for (int k = 0; k < block_w / 4; k++) begin
      res[4*k +: 4] = inv ? sbox4_inv[data[4*k +: 4]] : sbox4[data[4*k +: 4]];
    end
    return res;
  endfunction

  // bit k moves to position 16*k mod 63, bit 63 stays put
  function automatic block_t perm_f(block_t data, bit inv);
    block_t res;
    for (int k = 0; k < block_w - 1; k++) begin
      if (inv) begin
        res[k] = data[(k * 16) % 63];
      end else begin
        res[(k * 16) % 63] = data[k];
      end
    end
    res[block_w-1] = data[block_w-1];
    return res;
  endfunction

  // 128-bit key schedule step: rotate left 61, two s-boxes, counter xor
  function automatic key_t update_key_f(key_t key, idx_t idx);
    key_t res;
    res = {key[66:0], key[127:67]};
    res[127:124] = sbox4[res[127:124]];
    res[123:120] = sbox4[res[123:120]];
    res[66:62]   = res[66:62] ^ idx;
    return res;
  endfunction

  // undo one schedule step, same index as the forward step
  function automatic key_t inv_update_key_f(key_t key, idx_t idx);
    key_t res;
    res = key;
    res[66:62]   = res[66:62] ^ idx;
    res[127:124] = sbox4_inv[res[127:124]];
    res[123:120] = sbox4_inv[res[123:120]];
    return {res[60:0], res[127:61]};
  endfunction

  // key add, s-box, permutation
  function automatic block_t enc_round_f(block_t data, block_t round_key);
    return perm_f(sbox_layer_f(data ^ round_key, 1'b0), 1'b0);
  endfunction

  // key add, inverse permutation, inverse s-box
  function automatic block_t dec_round_f(block_t data, block_t round_key);
    return sbox_layer_f(perm_f(data ^ round_key, 1'b1), 1'b1);
  endfunction

  // decryption starts from the last round key, so run the schedule forward
  function automatic key_t dec_key_f(key_t key, int unsigned rounds);
    key_t res;
    res = key;
    for (int unsigned k = 1; k <= rounds; k++) begin
      res = update_key_f(res, idx_t'(k));
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: design/present_round.sv
`timescale 1ns/10ps
`default_nettype none

module present_round #(
  parameter bit Decrypt = 1'b0
) (
  input  present_pkg::block_t data_i,
  input  present_pkg::key_t   key_i,
  input  present_pkg::idx_t   idx_i,
  output present_pkg::block_t data_o,
  output present_pkg::key_t   key_o,
  output present_pkg::idx_t   idx_o
);

  // state arrives with this round's key already added, by the load
  // or by the previous round, so only the next round key goes in here
  present_pkg::block_t rkey_out, round_out;

  // round keys are the upper 64 key bits
  assign rkey_out = key_o[present_pkg::key_w-1 -: present_pkg::block_w];

  if (Decrypt) begin : gen_dec
    // schedule steps back, index counts down to 1
    assign key_o     = present_pkg::inv_update_key_f(key_i, idx_i);
    assign idx_o     = idx_i - present_pkg::idx_t'(1);
    assign round_out = present_pkg::dec_round_f(data_i, '0);
  end else begin : gen_enc
    // schedule steps forward, index counts up from 1
    assign key_o     = present_pkg::update_key_f(key_i, idx_i);
    assign idx_o     = idx_i + present_pkg::idx_t'(1);
    assign round_out = present_pkg::enc_round_f(data_i, '0);
  end

  // next round key on top, after the last round this is the finished block
  assign data_o = round_out ^ rkey_out;

endmodule

`default_nettype wire

// File: design/scrmbl_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface scrmbl_ctrl_if;

  // mux selects for the working registers
  scrmbl_pkg::data_sel_e        data_sel;
  scrmbl_pkg::key_sel_e         key_sel;
  // register enables
  logic                         data_en;
  logic                         key_en;
  logic                         shadow_load;
  logic                         digest_init;
  logic                         digest_en;
  // table index, taken from sel_i on the accept edge
  logic [scrmbl_pkg::sel_w-1:0] key_sel_idx;
  // last round of an operation
  logic                         done;

  modport decode_mp (
    output data_sel, key_sel, data_en, key_en, shadow_load, digest_init, digest_en,
           key_sel_idx, done
  );

  modport execute_mp (
    input data_sel, key_sel, data_en, key_en, shadow_load, digest_init, digest_en,
          key_sel_idx
  );

  modport result_mp (
    input digest_init, digest_en, done, key_sel_idx
  );

endinterface

`default_nettype wire

// File: design/scrmbl_decode.sv
`timescale 1ns/10ps
`default_nettype none

module scrmbl_decode #(
  parameter int unsigned NumRounds = 31
) (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  scrmbl_pkg::cmd_e              cmd_i,
  input  wire [scrmbl_pkg::sel_w-1:0]   sel_i,
  input  wire                           valid_i,
  output logic                          ready_o,
  scrmbl_ctrl_if.decode_mp              ctrl_o
);

  // counter wide enough to hold NumRounds-1, at least one bit
  localparam int CntW = $clog2(NumRounds + 1);
  localparam logic [CntW-1:0] LastRound = CntW'(NumRounds - 1);

  scrmbl_pkg::state_e state_d, state_q;
  logic [CntW-1:0]    cnt_d, cnt_q;
  logic               last_round;

  assign last_round = (cnt_q == LastRound);

  // tables are indexed straight from the command sel
  assign ctrl_o.key_sel_idx = sel_i;

  //////////////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    cnt_d              = cnt_q;
    ready_o            = 1'b0;
    ctrl_o.data_sel    = scrmbl_pkg::sel_data_in;
    ctrl_o.key_sel     = scrmbl_pkg::sel_digest_in;
    ctrl_o.data_en     = 1'b0;
    ctrl_o.key_en      = 1'b0;
    ctrl_o.shadow_load = 1'b0;
    ctrl_o.digest_init = 1'b0;
    ctrl_o.digest_en   = 1'b0;
    ctrl_o.done        = 1'b0;

    case (state_q)
      // waiting for a command, load working regs on accept
      scrmbl_pkg::st_idle: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          case (cmd_i)
            scrmbl_pkg::cmd_decrypt: begin
              state_d        = scrmbl_pkg::st_decrypt;
              ctrl_o.key_sel = scrmbl_pkg::sel_dec_key_init;
              ctrl_o.data_en = 1'b1;
              ctrl_o.key_en  = 1'b1;
            end
            scrmbl_pkg::cmd_encrypt: begin
              state_d        = scrmbl_pkg::st_encrypt;
              ctrl_o.key_sel = scrmbl_pkg::sel_enc_key_init;
              ctrl_o.data_en = 1'b1;
              ctrl_o.key_en  = 1'b1;
            end
            // lower key half for the next digest step
            scrmbl_pkg::cmd_load_shadow: ctrl_o.shadow_load = 1'b1;
            // digest state is the plaintext, {data_i, shadow} the key
            scrmbl_pkg::cmd_digest: begin
              state_d         = scrmbl_pkg::st_digest;
              ctrl_o.data_sel = scrmbl_pkg::sel_digest_state;
              ctrl_o.data_en  = 1'b1;
              ctrl_o.key_en   = 1'b1;
            end
            scrmbl_pkg::cmd_digest_init: begin
              ctrl_o.digest_init = 1'b1;
              ctrl_o.digest_en   = 1'b1;
            end
            default: ;
          endcase
        end
      end
      // inverse rounds, key schedule runs backwards
      scrmbl_pkg::st_decrypt: begin
        ctrl_o.data_sel = scrmbl_pkg::sel_dec_out;
        ctrl_o.key_sel  = scrmbl_pkg::sel_dec_key_out;
      end
      // encrypt and digest share the forward rounds
      default: begin
        ctrl_o.data_sel = scrmbl_pkg::sel_enc_out;
        ctrl_o.key_sel  = scrmbl_pkg::sel_enc_key_out;
      end
    endcase

    // common round handling for all busy states
    if (state_q != scrmbl_pkg::st_idle) begin
      ctrl_o.data_en = 1'b1;
      ctrl_o.key_en  = 1'b1;
      cnt_d          = cnt_q + CntW'(1);
      if (last_round) begin
        state_d     = scrmbl_pkg::st_idle;
        ctrl_o.done = 1'b1;
        // davies-meyer feed-forward, and keep a copy of the new state
        if (state_q == scrmbl_pkg::st_digest) begin
          ctrl_o.data_sel  = scrmbl_pkg::sel_enc_out_xor;
          ctrl_o.digest_en = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= scrmbl_pkg::st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: design/scrmbl_execute.sv
`timescale 1ns/10ps
`default_nettype none

module scrmbl_execute #(
  parameter int unsigned            NumRounds = 31,
  parameter scrmbl_pkg::key_table_t KeyTable  = scrmbl_pkg::default_keys
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  present_pkg::block_t data_i,
  scrmbl_ctrl_if.execute_mp   ctrl_i,
  input  present_pkg::block_t digest_state_i,
  input  present_pkg::block_t enc_out_xor_i,
  output present_pkg::block_t data_state_o,
  output present_pkg::block_t enc_out_o
);

  //////////////////////////////////////////////////////////////////////////////
  // decryption key table
  //////////////////////////////////////////////////////////////////////////////

  scrmbl_pkg::key_table_t dec_key_lut;

  // constant per key, resolved at elaboration
  for (genvar k = 0; k < scrmbl_pkg::num_keys; k++) begin : gen_dec_keys
    localparam present_pkg::key_t DecKey = present_pkg::dec_key_f(KeyTable[k], NumRounds);
    assign dec_key_lut[k] = DecKey;
  end

  //////////////////////////////////////////////////////////////////////////////
  // working registers and their muxes
  //////////////////////////////////////////////////////////////////////////////

  present_pkg::key_t   key_d, key_q, enc_key, dec_key;
  present_pkg::idx_t   idx_d, idx_q, enc_idx, dec_idx;
  present_pkg::block_t data_d, data_q, shadow_q, enc_data, dec_data;
  present_pkg::block_t first_rkey;

  // first round key goes in on load, each round adds the next one
  assign first_rkey = key_d[present_pkg::key_w-1 -: present_pkg::block_w];

  always_comb begin
    case (ctrl_i.data_sel)
      scrmbl_pkg::sel_enc_out:      data_d = enc_data;
      scrmbl_pkg::sel_dec_out:      data_d = dec_data;
      scrmbl_pkg::sel_digest_state: data_d = digest_state_i ^ first_rkey;
      scrmbl_pkg::sel_enc_out_xor:  data_d = enc_out_xor_i;
      default:                      data_d = data_i ^ first_rkey;
    endcase
  end

  // index starts at 1 except for decrypt, which counts down from NumRounds
  always_comb begin
    case (ctrl_i.key_sel)
      scrmbl_pkg::sel_enc_key_out: begin
        key_d = enc_key;
        idx_d = enc_idx;
      end
      scrmbl_pkg::sel_dec_key_out: begin
        key_d = dec_key;
        idx_d = dec_idx;
      end
      scrmbl_pkg::sel_enc_key_init: begin
        key_d = KeyTable[ctrl_i.key_sel_idx];
        idx_d = present_pkg::idx_t'(1);
      end
      scrmbl_pkg::sel_dec_key_init: begin
        key_d = dec_key_lut[ctrl_i.key_sel_idx];
        idx_d = present_pkg::idx_t'(NumRounds);
      end
      // digest key is the new block above the shadowed one
      default: begin
        key_d = {data_i, shadow_q};
        idx_d = present_pkg::idx_t'(1);
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q    <= '0;
      idx_q    <= '0;
      data_q   <= '0;
      shadow_q <= '0;
    end else begin
      if (ctrl_i.key_en) begin
        key_q <= key_d;
        idx_q <= idx_d;
      end
      if (ctrl_i.data_en) begin
        data_q <= data_d;
      end
      if (ctrl_i.shadow_load) begin
        shadow_q <= data_i;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // round logic
  //////////////////////////////////////////////////////////////////////////////

  present_round #(
    .Decrypt(1'b0)
  ) u_enc_round (
    .data_i(data_q),
    .key_i (key_q),
    .idx_i (idx_q),
    .data_o(enc_data),
    .key_o (enc_key),
    .idx_o (enc_idx)
  );

  present_round #(
    .Decrypt(1'b1)
  ) u_dec_round (
    .data_i(data_q),
    .key_i (key_q),
    .idx_i (idx_q),
    .data_o(dec_data),
    .key_o (dec_key),
    .idx_o (dec_idx)
  );

  assign data_state_o = data_q;
  assign enc_out_o    = enc_data;

endmodule

`default_nettype wire

// File: design/scrmbl_pkg.sv
`default_nettype none

package scrmbl_pkg;

  // command set, unused codes are dropped in idle
  typedef enum logic [2:0] {
    cmd_decrypt,
    cmd_encrypt,
    cmd_load_shadow,
    cmd_digest,
    cmd_digest_init
  } cmd_e;

  // idle plus one busy state per round type
  typedef enum logic [1:0] {
    st_idle,
    st_decrypt,
    st_encrypt,
    st_digest
  } state_e;

  // data state register source
  typedef enum logic [2:0] {
    sel_enc_out,
    sel_dec_out,
    sel_digest_state,
    sel_enc_out_xor,
    sel_data_in
  } data_sel_e;

  // key register source
  typedef enum logic [2:0] {
    sel_enc_key_out,
    sel_dec_key_out,
    sel_enc_key_init,
    sel_dec_key_init,
    sel_digest_in
  } key_sel_e;

  localparam int num_keys = 4;
  localparam int num_ivs  = 2;
  localparam int sel_w    = 2;

  typedef logic [num_keys-1:0][present_pkg::key_w-1:0] key_table_t;
  typedef logic [num_ivs-1:0][present_pkg::block_w-1:0] iv_table_t;

  // entry 0 sits in the low bits
  localparam key_table_t default_keys = {
    128'h5a3c_91e7_0d42_b86f_c31a_7e95_24d0_6bf8,
    128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0,
    128'hd7a2_4c19_e630_58bf_2a9e_71c4_0b6d_f385,
    128'h3b8e_f104_9c67_2ad5_86f2_4e1b_d039_75ac
  };

  localparam iv_table_t default_ivs = {
    64'h7c41_e9a2_305b_d68f,
    64'h19f6_83c2_ae57_0d4b
  };

endpackage

`default_nettype wire

// File: design/scrmbl_result.sv
`timescale 1ns/10ps
`default_nettype none

module scrmbl_result #(
  parameter scrmbl_pkg::iv_table_t IvTable = scrmbl_pkg::default_ivs
) (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  scrmbl_ctrl_if.result_mp    ctrl_i,
  input  present_pkg::block_t data_state_i,
  input  present_pkg::block_t enc_out_i,
  output present_pkg::block_t digest_state_o,
  output present_pkg::block_t enc_out_xor_o,
  output present_pkg::block_t data_o,
  output logic                valid_o
);

  // only the low sel bits address the iv table
  localparam int IvSelW = $clog2(scrmbl_pkg::num_ivs);

  present_pkg::block_t digest_d, digest_q;
  logic                valid_q;

  // davies-meyer, cipher output xor the chaining value
  assign enc_out_xor_o = enc_out_i ^ digest_q;

  // iv on init, otherwise the finished digest step
  assign digest_d = ctrl_i.digest_init ? IvTable[ctrl_i.key_sel_idx[IvSelW-1:0]]
                                       : enc_out_xor_o;

  // digest state lives here so encrypt and decrypt can run in between
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= ctrl_i.done;
      if (ctrl_i.digest_en) begin
        digest_q <= digest_d;
      end
    end
  end

  assign digest_state_o = digest_q;
  assign valid_o        = valid_q;
  // result only visible in the valid cycle
  assign data_o         = valid_q ? data_state_i : '0;

endmodule

`default_nettype wire

// File: dv/scrmbl_checker.sv
`timescale 1ns/10ps
`default_nettype none

module scrmbl_checker (
  input wire                 clk_i,
  input wire                 rst_ni,
  input wire                 ready_i,
  input wire                 out_valid_i,
  input present_pkg::block_t out_data_i,
  input scrmbl_pkg::state_e  state_i
);

  // result strobe lasts one cycle, nothing holds it
  valid_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_i |=> !out_valid_i)
    else $error("valid_o stayed high for more than one cycle");

  // output bus is gated to zero outside the valid cycle
  data_gated_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !out_valid_i |-> (out_data_i == '0))
    else $error("data_o not zero while valid_o is low");

  // no command accepted while rounds are running
  busy_not_ready_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i != scrmbl_pkg::st_idle) |-> !ready_i)
    else $error("ready_o high while the FSM is busy");

endmodule

bind otp_scrmbl_top scrmbl_checker i_scrmbl_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ready_i    (ready_o),
  .out_valid_i(valid_o),
  .out_data_i (data_o),
  .state_i    (u_decode.state_q)
);

`default_nettype wire

// File: dv/tb_otp_scrmbl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_otp_scrmbl;

  localparam int unsigned num_rounds = 31;
  localparam int          num_rows   = 15;
  localparam int          max_cycles = num_rows * (num_rounds + 4) + 100;

  // published PRESENT-128 ciphertext for zero key and zero block
  localparam present_pkg::block_t zero_ct = 64'h96db702a2e6900af;

  // key 0 all zero, iv 0 zero, the rest from the defaults
  localparam scrmbl_pkg::key_table_t tb_keys = {
    scrmbl_pkg::default_keys[3], scrmbl_pkg::default_keys[2],
    scrmbl_pkg::default_keys[1], 128'h0
  };
  localparam scrmbl_pkg::iv_table_t tb_ivs = {scrmbl_pkg::default_ivs[1], 64'h0};

  typedef struct packed {
    scrmbl_pkg::cmd_e             cmd;
    logic [scrmbl_pkg::sel_w-1:0] sel;
    present_pkg::block_t          data;
    bit                           use_prev;
    bit                           early;
    bit                           exp_valid;
    bit                           chk;
    present_pkg::block_t          exp;
  } row_t;

  logic                         clk;
  logic                         rst_n;
  scrmbl_pkg::cmd_e             cmd;
  logic [scrmbl_pkg::sel_w-1:0] sel;
  present_pkg::block_t          data_in;
  logic                         valid;
  logic                         ready;
  present_pkg::block_t          data_out;
  logic                         valid_out;

  row_t                rows [num_rows];
  present_pkg::block_t last_result;
  logic [31:0]         lfsr;
  int                  cycle_cnt;

  otp_scrmbl_top #(
    .NumRounds(num_rounds),
    .KeyTable (tb_keys),
    .IvTable  (tb_ivs)
  ) i_otp_scrmbl_top (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .cmd_i  (cmd),
    .sel_i  (sel),
    .data_i (data_in),
    .valid_i(valid),
    .ready_o(ready),
    .data_o (data_out),
    .valid_o(valid_out)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_block(input string name, input present_pkg::block_t act,
                             input present_pkg::block_t exp);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp) begin
      abort_run($sformatf("[FAIL] %t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  // watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_run($sformatf("timeout, no verdict after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_block(output present_pkg::block_t blk);
    blk = '0;
    for (int b = 0; b < present_pkg::block_w; b++) begin
      lfsr   = lfsr_next(lfsr);
      blk[b] = lfsr[0];
    end
  endtask

  function automatic row_t make_row(input scrmbl_pkg::cmd_e cmd_v,
                                    input logic [scrmbl_pkg::sel_w-1:0] sel_v,
                                    input present_pkg::block_t data_v, input bit use_prev,
                                    input bit early, input bit exp_valid, input bit chk,
                                    input present_pkg::block_t exp);
    row_t row;
    row.cmd       = cmd_v;
    row.sel       = sel_v;
    row.data      = data_v;
    row.use_prev  = use_prev;
    row.early     = early;
    row.exp_valid = exp_valid;
    row.chk       = chk;
    row.exp       = exp;
    return row;
  endfunction

  // columns: cmd, sel, data, take last result, held while busy, valid, compare, expected
  task automatic build_table();
    present_pkg::block_t rnd_a, rnd_b, rnd_c;
    draw_block(rnd_a);
    draw_block(rnd_b);
    draw_block(rnd_c);
    // known answer both ways under the zero key
    rows[0]  = make_row(scrmbl_pkg::cmd_encrypt, 2'd0, '0, 1'b0, 1'b0, 1'b1, 1'b1, zero_ct);
    rows[1]  = make_row(scrmbl_pkg::cmd_decrypt, 2'd0, zero_ct, 1'b0, 1'b0, 1'b1, 1'b1, '0);
    // random round trip under key 1
    rows[2]  = make_row(scrmbl_pkg::cmd_encrypt, 2'd1, rnd_a, 1'b0, 1'b0, 1'b1, 1'b0, '0);
    rows[3]  = make_row(scrmbl_pkg::cmd_decrypt, 2'd1, '0, 1'b1, 1'b0, 1'b1, 1'b1, rnd_a);
    // digest of a zero block from iv 0 with a zero shadow
    rows[4]  = make_row(scrmbl_pkg::cmd_digest_init, 2'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    rows[5]  = make_row(scrmbl_pkg::cmd_load_shadow, 2'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    rows[6]  = make_row(scrmbl_pkg::cmd_digest, 2'd0, '0, 1'b0, 1'b0, 1'b1, 1'b1, zero_ct);
    // same digest with an encrypt in between
    rows[7]  = make_row(scrmbl_pkg::cmd_digest_init, 2'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    rows[8]  = make_row(scrmbl_pkg::cmd_load_shadow, 2'd0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    rows[9]  = make_row(scrmbl_pkg::cmd_encrypt, 2'd1, rnd_b, 1'b0, 1'b0, 1'b1, 1'b0, '0);
    rows[10] = make_row(scrmbl_pkg::cmd_digest, 2'd0, '0, 1'b0, 1'b0, 1'b1, 1'b1, zero_ct);
    // decrypt held on the bus during the encrypt
    rows[11] = make_row(scrmbl_pkg::cmd_encrypt, 2'd0, '0, 1'b0, 1'b0, 1'b1, 1'b1, zero_ct);
    rows[12] = make_row(scrmbl_pkg::cmd_decrypt, 2'd0, zero_ct, 1'b0, 1'b1, 1'b1, 1'b1, '0);
    rows[13] = make_row(scrmbl_pkg::cmd_encrypt, 2'd1, rnd_c, 1'b0, 1'b0, 1'b1, 1'b0, '0);
    rows[14] = make_row(scrmbl_pkg::cmd_decrypt, 2'd1, '0, 1'b1, 1'b0, 1'b1, 1'b1, rnd_c);
  endtask

  task automatic drive_row(input int r);
    cmd     = rows[r].cmd;
    sel     = rows[r].sel;
    data_in = rows[r].use_prev ? last_result : rows[r].data;
    valid   = 1'b1;
  endtask

  // entered on a falling edge with row r on the inputs
  task automatic run_row(input int r);
    int lat;
    check_flag("ready_o", ready, 1'b1);
    @(negedge clk);
    lat = 1;
    // a held row goes on the bus right after the accept edge
    if (r + 1 < num_rows && rows[r + 1].early) begin
      drive_row(r + 1);
    end else begin
      valid = 1'b0;
    end
    if (rows[r].exp_valid) begin
      while (!valid_out) begin
        check_flag("ready_o", ready, 1'b0);
        @(negedge clk);
        lat++;
      end
      check_count("valid_o latency", lat, int'(num_rounds) + 1);
      check_flag("ready_o", ready, 1'b1);
      if (rows[r].chk) begin
        check_block("data_o", data_out, rows[r].exp);
      end
      last_result = data_out;
    end else begin
      check_flag("valid_o", valid_out, 1'b0);
      check_flag("ready_o", ready, 1'b1);
    end
  endtask

  initial begin
    $timeformat(-9, 2, " ns", 10);
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd         = scrmbl_pkg::cmd_decrypt;
    sel         = '0;
    data_in     = '0;
    valid       = 1'b0;
    last_result = '0;
    lfsr        = 32'hec45843d;
    cycle_cnt   = 0;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // idle after reset
    check_flag("ready_o", ready, 1'b1);
    check_flag("valid_o", valid_out, 1'b0);
    for (int r = 0; r < num_rows; r++) begin
      if (!rows[r].early) begin
        drive_row(r);
      end
      run_row(r);
    end
    @(negedge clk);
    check_flag("valid_o", valid_out, 1'b0);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_otp_scrmbl -o tb_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_sim 2>&1)"
echo "$out"
grep -qx "test passed" <<< "$out" && exit 0 || exit 1

// File: sim.f
design/present_pkg.sv
design/scrmbl_pkg.sv
design/scrmbl_ctrl_if.sv
design/present_round.sv
design/scrmbl_decode.sv
design/scrmbl_execute.sv
design/scrmbl_result.sv
design/otp_scrmbl_top.sv
dv/scrmbl_checker.sv
dv/tb_otp_scrmbl.sv
